// File: test/program_input.txt
# P image byte_address instruction
# S image byte_address store_data byte_enable
P 0 00000000 20000093
P 0 00000004 FFB00113
P 0 00000008 00700193
P 0 0000000C 40218233
P 0 00000010 0040A023
P 0 00000014 40115293
P 0 00000018 0050A223
P 0 0000001C 00312333
P 0 00000020 003133B3
P 0 00000024 00619433
P 0 00000028 006084A3
P 0 0000002C 00809523
P 0 00000030 0070A623
P 0 00000034 00408503
P 0 00000038 0040D583
P 0 0000003C 00A09603
P 0 00000040 0050C683
P 0 00000044 0000A703
P 0 00000048 00A0A823
P 0 0000004C 00B0AA23
P 0 00000050 00C0AC23
P 0 00000054 00D0AE23
P 0 00000058 02E0A023
P 0 0000005C 00218463
P 0 00000060 0230A223
P 0 00000064 00314463
P 0 00000068 0000A023
P 0 0000006C 008007EF
P 0 00000070 0000A023
P 0 00000074 02F0A423
P 0 00000078 08100813
P 0 0000007C 008808E7
P 0 00000080 0000A023
P 0 00000084 0000A023
P 0 00000088 0310A623
P 0 0000008C 12345937
P 0 00000090 00001997
P 0 00000094 0320A823
P 0 00000098 0330AA23
P 0 0000009C 0000006F
S 0 00000200 0000000C F
S 0 00000204 FFFFFFFD F
S 0 00000208 00000100 2
S 0 00000208 000E0000 C
S 0 0000020C 00000000 F
S 0 00000210 FFFFFFFD F
S 0 00000214 0000FFFD F
S 0 00000218 0000000E F
S 0 0000021C 000000FF F
S 0 00000220 0000000C F
S 0 00000224 00000007 F
S 0 00000228 00000070 F
S 0 0000022C 00000080 F
S 0 00000230 12345000 F
S 0 00000234 00001090 F
P 1 00000000 20000093
P 1 00000004 0010A023
P 1 00000008 00000073
P 1 0000000C 0010A223
P 1 00000010 0000006F
S 1 00000200 00000200 F

// File: tb.f
source/rv32_pkg.sv
source/control_unit.sv
source/reg_file.sv
source/fetch_unit.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/exec_unit.sv
source/core_top.sv
test/core_asserts.sv
test/tb_core.sv

// File: Makefile
SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_core

obj_dir/Vtb_core: tb.f $(SOURCES)
	verilator --binary --timing --assert -f tb.f --top-module tb_core -Mdir obj_dir -o Vtb_core

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core

clean:
	rm -rf obj_dir

// File: test/tb_core.sv
// Memory model covers 1 KB from address 0; expects the core to start at address 0
`timescale 1ns/1ps
`default_nettype none

module tb_core import rv32_pkg::*;;

  logic     clk;
  logic     reset_i;
  bus_req_t mem_req_o;
  word_t    mem_rdata_i;
  logic     halt_o;
  logic     illegal_o;

  word_t      mem [256];
  word_t      rd_pending;
  logic       stopped;
  int         limit_cycles;

  // Whole input file, both images
  int         prog_img [$];
  word_t      prog_addr [$];
  word_t      prog_data [$];
  int         st_img [$];
  word_t      st_addr [$];
  word_t      st_data [$];
  logic [3:0] st_be [$];

  // Stores still expected from the running image
  word_t      exp_addr [$];
  word_t      exp_data [$];
  logic [3:0] exp_be [$];

  core_top #(
    .RESET_PC (32'h0000_0000)
  ) u_dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .mem_req_o   (mem_req_o),
    .mem_rdata_i (mem_rdata_i),
    .halt_o      (halt_o),
    .illegal_o   (illegal_o)
  );

  always #10 clk = ~clk;

  task automatic report_failure();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic read_input_file();
    int         fd;
    int         n;
    string      line;
    logic [7:0] kind;
    int         img;
    word_t      a;
    word_t      d;
    logic [3:0] be;
    fd = $fopen("test/program_input.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open test/program_input.txt");
      report_failure();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n <= 1 || line.getc(0) == "#") continue;
      be = 4'h0;
      n = $sscanf(line, "%c %d %h %h %h", kind, img, a, d, be);
      if (kind == "P") begin
        prog_img.push_back(img);
        prog_addr.push_back(a);
        prog_data.push_back(d);
      end else if (kind == "S") begin
        st_img.push_back(img);
        st_addr.push_back(a);
        st_data.push_back(d);
        st_be.push_back(be);
      end
    end
    $fclose(fd);
  endtask

  // Fill, then place one image and its expected stores
  task automatic load_image(input int img);
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a5a_0000 ^ (word_t'(i) << 2);
    end
    exp_addr.delete();
    exp_data.delete();
    exp_be.delete();
    foreach (prog_img[i]) begin
      if (prog_img[i] == img) mem[prog_addr[i][9:2]] = prog_data[i];
    end
    foreach (st_img[i]) begin
      if (st_img[i] == img) begin
        exp_addr.push_back(st_addr[i]);
        exp_data.push_back(st_data[i]);
        exp_be.push_back(st_be[i]);
      end
    end
  endtask

  task automatic check_store(input bus_req_t req);
    word_t      e_addr;
    word_t      e_data;
    logic [3:0] e_be;
    assert (exp_addr.size() > 0) else begin
      $display("Store to %h at %0t was not expected", req.addr, $time);
      report_failure();
    end
    e_addr = exp_addr.pop_front();
    e_data = exp_data.pop_front();
    e_be   = exp_be.pop_front();
    assert (req.addr == e_addr) else begin
      $display("ERROR %0t mem_req_o.addr got %h expected %h", $time, req.addr, e_addr);
      report_failure();
    end
    assert (req.be == e_be) else begin
      $display("ERROR %0t mem_req_o.be got %h expected %h", $time, req.be, e_be);
      report_failure();
    end
    assert (req.wdata == e_data) else begin
      $display("ERROR %0t mem_req_o.wdata got %h expected %h", $time, req.wdata, e_data);
      report_failure();
    end
  endtask

  // Memory model, one cycle read latency, writes land in the request cycle
  always @(negedge clk) begin
    mem_rdata_i = rd_pending;
    if (!reset_i && mem_req_o.req) begin
      assert (!stopped) else begin
        $display("Bus request at %0t after the core stopped", $time);
        report_failure();
      end
      if (mem_req_o.we) begin
        check_store(mem_req_o);
        for (int b = 0; b < 4; b++) begin
          if (mem_req_o.be[b]) begin
            mem[mem_req_o.addr[9:2]][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
          end
        end
      end else begin
        rd_pending = mem[mem_req_o.addr[9:2]];
      end
    end
  end

  task automatic run_image(input int img, input logic expect_illegal);
    @(negedge clk);
    reset_i = 1'b1;
    stopped = 1'b0;
    load_image(img);
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    while (!(halt_o || illegal_o)) @(negedge clk);
    stopped = 1'b1;
    assert (illegal_o == expect_illegal) else begin
      $display("ERROR %0t illegal_o got %b expected %b", $time, illegal_o, expect_illegal);
      report_failure();
    end
    assert (exp_addr.size() == 0) else begin
      $display("Image %0d stopped with %0d stores missing", img, exp_addr.size());
      report_failure();
    end
    // Status must hold and the bus stay quiet
    repeat (10) begin
      @(negedge clk);
      assert (halt_o == !expect_illegal) else begin
        $display("ERROR %0t halt_o got %b expected %b", $time, halt_o, !expect_illegal);
        report_failure();
      end
      assert (illegal_o == expect_illegal) else begin
        $display("ERROR %0t illegal_o got %b expected %b", $time, illegal_o, expect_illegal);
        report_failure();
      end
    end
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles", limit_cycles);
    report_failure();
  end

  initial begin
    clk         = 1'b0;
    reset_i     = 1'b1;
    mem_rdata_i = '0;
    rd_pending  = '0;
    stopped     = 1'b0;
    read_input_file();
    limit_cycles = prog_data.size() * 8 * 4;
    run_image(0, 1'b0);
    run_image(1, 1'b1);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/core_asserts.sv
// Bus protocol checks bound into bus_arbiter; assumes a synchronous active-high reset
`timescale 1ns/1ps
`default_nettype none

module core_asserts import rv32_pkg::*; (
  input logic       clk,
  input logic       reset_i,
  input bus_req_t   fetch_req_i,
  input bus_req_t   data_req_i,
  input logic       fetch_grant_o,
  input logic       data_grant_o,
  input bus_req_t   bus_o,
  input logic [1:0] granted_q
);

  // Never two owners in one cycle
  a_one_grant: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({fetch_grant_o, data_grant_o}))
    else $error("Fetch and data granted in the same cycle");

  // A granted strobe drops on the next cycle
  a_strobe_once: assert property (@(posedge clk) disable iff (reset_i)
    (!granted_q[1] || !data_req_i.req) && (!granted_q[0] || !fetch_req_i.req))
    else $error("Request still held in the cycle after its grant");

  // Outputs are cleared one edge into reset
  a_no_req_in_reset: assert property (@(posedge clk)
    (reset_i && $past(reset_i)) |-> !bus_o.req)
    else $error("Bus request while reset is held");

  a_write_from_data: assert property (@(posedge clk) disable iff (reset_i)
    bus_o.we |-> (data_grant_o && data_req_i.we && !fetch_req_i.we))
    else $error("Bus write not issued by the data requester");

endmodule

bind bus_arbiter core_asserts u_asserts (
  .clk           (clk),
  .reset_i       (reset_i),
  .fetch_req_i   (fetch_req_i),
  .data_req_i    (data_req_i),
  .fetch_grant_o (fetch_grant_o),
  .data_grant_o  (data_grant_o),
  .bus_o         (bus_o),
  .granted_q     (granted_q)
);

`default_nettype wire

// File: source/core_top.sv
// Single shared memory bus with fixed one-cycle read latency and no stalls
`timescale 1ns/1ps
`default_nettype none

module core_top import rv32_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     reset_i,
  output bus_req_t mem_req_o,
  input  word_t    mem_rdata_i,
  output logic     halt_o,
  output logic     illegal_o
);

  bus_req_t fetch_req, data_req;
  logic     fetch_grant, data_grant;
  instr_t   instr;
  logic     instr_valid;
  word_t    pc, next_pc;
  ctrl_t    ctrl;
  logic     retire;
  logic     mem_start, mem_done;
  word_t    mem_addr, store_data, load_data;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_o         (fetch_req),
    .grant_i       (fetch_grant),
    .rdata_i       (mem_rdata_i),
    .retire_i      (retire),
    .next_pc_i     (next_pc),
    .instr_o       (instr),
    .instr_valid_o (instr_valid),
    .pc_o          (pc)
  );

  control_unit u_decode (
    .instr_i (instr),
    .ctrl_o  (ctrl)
  );

  load_store_unit u_lsu (
    .clk          (clk),
    .reset_i      (reset_i),
    .start_i      (mem_start),
    .ctrl_i       (ctrl),
    .addr_i       (mem_addr),
    .store_data_i (store_data),
    .bus_o        (data_req),
    .grant_i      (data_grant),
    .rdata_i      (mem_rdata_i),
    .done_o       (mem_done),
    .load_data_o  (load_data)
  );

  bus_arbiter u_arbiter (
    .clk           (clk),
    .reset_i       (reset_i),
    .fetch_req_i   (fetch_req),
    .data_req_i    (data_req),
    .fetch_grant_o (fetch_grant),
    .data_grant_o  (data_grant),
    .bus_o         (mem_req_o)
  );

  exec_unit u_exec (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid),
    .pc_i          (pc),
    .ctrl_i        (ctrl),
    .mem_done_i    (mem_done),
    .load_data_i   (load_data),
    .mem_start_o   (mem_start),
    .mem_addr_o    (mem_addr),
    .store_data_o  (store_data),
    .retire_o      (retire),
    .next_pc_o     (next_pc),
    .halt_o        (halt_o),
    .illegal_o     (illegal_o)
  );

endmodule

`default_nettype wire

// File: source/exec_unit.sv
// Executes one instruction per instr_valid pulse; stops for good on halt or illegal
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv32_pkg::*; (
  input  logic  clk,
  input  logic  reset_i,
  input  logic  instr_valid_i,
  input  word_t pc_i,
  input  ctrl_t ctrl_i,
  input  logic  mem_done_i,
  input  word_t load_data_i,
  output logic  mem_start_o,
  output word_t mem_addr_o,
  output word_t store_data_o,
  output logic  retire_o,
  output word_t next_pc_o,
  output logic  halt_o,
  output logic  illegal_o
);

  typedef enum logic [1:0] {IDLE, MEM_WAIT, STOPPED} exec_state_t;

  exec_state_t state;
  logic        halt_q, illegal_q;
  logic        is_mem, stop, taken;
  word_t       rs1_val, rs2_val, op_a, op_b, alu_res, pc_plus4, wdata;

  reg_file u_reg_file (
    .clk      (clk),
    .reset_i  (reset_i),
    .rs1_i    (ctrl_i.rs1),
    .rs2_i    (ctrl_i.rs2),
    .rd_i     (ctrl_i.rd),
    .wen_i    (retire_o && ctrl_i.wen),
    .wdata_i  (wdata),
    .rdata1_o (rs1_val),
    .rdata2_o (rs2_val)
  );

  assign op_a = (ctrl_i.asel == ASEL_PC) ? pc_i : rs1_val;
  assign op_b = (ctrl_i.bsel == BSEL_IMM) ? ctrl_i.imm : rs2_val;

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_a + op_b;
    endcase
  end

  // Branch compare always on the two register values
  always_comb begin
    case (ctrl_i.branch_type)
      BEQ:     taken = (rs1_val == rs2_val);
      BNE:     taken = (rs1_val != rs2_val);
      BLT:     taken = ($signed(rs1_val) < $signed(rs2_val));
      BGE:     taken = ($signed(rs1_val) >= $signed(rs2_val));
      BLTU:    taken = (rs1_val < rs2_val);
      default: taken = (rs1_val >= rs2_val);
    endcase
  end

  assign pc_plus4 = pc_i + 32'd4;

  always_comb begin
    if (ctrl_i.jalr) begin
      next_pc_o = {alu_res[31:1], 1'b0};
    end else if (ctrl_i.jump || (ctrl_i.branch && taken)) begin
      next_pc_o = pc_i + ctrl_i.imm;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

  always_comb begin
    case (ctrl_i.wsel)
      WSEL_LOAD: wdata = load_data_i;
      WSEL_PC4:  wdata = pc_plus4;
      WSEL_UIMM: wdata = ctrl_i.imm;
      default:   wdata = alu_res;
    endcase
  end

  assign is_mem = ctrl_i.dren || ctrl_i.dwen;
  assign stop   = ctrl_i.halt || ctrl_i.illegal;

  assign mem_start_o  = (state == IDLE) && instr_valid_i && is_mem && !stop;
  assign mem_addr_o   = alu_res;
  assign store_data_o = rs2_val;
  assign retire_o     = ((state == IDLE) && instr_valid_i && !is_mem && !stop) ||
                        ((state == MEM_WAIT) && mem_done_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state     <= IDLE;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (instr_valid_i) begin
            if (stop) begin
              state     <= STOPPED;
              halt_q    <= ctrl_i.halt && !ctrl_i.illegal;
              illegal_q <= ctrl_i.illegal;
            end else if (is_mem) begin
              state <= MEM_WAIT;
            end
          end
        end
        MEM_WAIT: begin
          if (mem_done_i) begin
            state <= IDLE;
          end
        end
        default: state <= STOPPED;
      endcase
    end
  end

  assign halt_o    = halt_q;
  assign illegal_o = illegal_q;

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
// Fixed priority, data over fetch; a loser must hold its request until granted
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import rv32_pkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  bus_req_t fetch_req_i,
  input  bus_req_t data_req_i,
  output logic     fetch_grant_o,
  output logic     data_grant_o,
  output bus_req_t bus_o
);

  // Owner of the previous bus cycle, bit 1 data and bit 0 fetch
  logic [1:0] granted_q;

  assign data_grant_o  = data_req_i.req;
  assign fetch_grant_o = fetch_req_i.req && !data_req_i.req;

  assign bus_o = data_req_i.req ? data_req_i : fetch_req_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      granted_q <= 2'b00;
    end else begin
      granted_q <= {data_grant_o, fetch_grant_o};
    end
  end

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
// Word-aligned bus address with byte lanes; misaligned halfwords and words are not trapped
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import rv32_pkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     start_i,
  input  ctrl_t    ctrl_i,
  input  word_t    addr_i,
  input  word_t    store_data_i,
  output bus_req_t bus_o,
  input  logic     grant_i,
  input  word_t    rdata_i,
  output logic     done_o,
  output word_t    load_data_o
);

  logic       req_q;
  logic       done_q;
  logic       we_q;
  logic [3:0] be_q;
  word_t      addr_q;
  word_t      wdata_q;
  load_t      type_q;
  logic [1:0] offset_q;
  word_t      lane_data;
  word_t      store_masked;
  logic [3:0] store_be;
  word_t      shifted;

  // Size masks then lane placement by address low bits
  always_comb begin
    case (ctrl_i.load_type)
      LB, LBU: begin
        store_masked = {24'b0, store_data_i[7:0]};
        store_be     = 4'b0001 << addr_i[1:0];
      end
      LH, LHU: begin
        store_masked = {16'b0, store_data_i[15:0]};
        store_be     = 4'b0011 << addr_i[1:0];
      end
      default: begin
        store_masked = store_data_i;
        store_be     = 4'b1111;
      end
    endcase
    lane_data = store_masked << {addr_i[1:0], 3'b000};
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      req_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= req_q && grant_i;
      if (start_i) begin
        req_q <= 1'b1;
      end else if (grant_i) begin
        req_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      we_q     <= ctrl_i.dwen;
      be_q     <= ctrl_i.dwen ? store_be : 4'hf;
      addr_q   <= {addr_i[31:2], 2'b00};
      wdata_q  <= lane_data;
      type_q   <= ctrl_i.load_type;
      offset_q <= addr_i[1:0];
    end
  end

  assign bus_o.req   = req_q;
  assign bus_o.we    = we_q;
  assign bus_o.be    = be_q;
  assign bus_o.addr  = addr_q;
  assign bus_o.wdata = wdata_q;

  // Read response is valid in the done cycle
  always_comb begin
    shifted = rdata_i >> {offset_q, 3'b000};
    case (type_q)
      LB:      load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      LH:      load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      LBU:     load_data_o = {24'b0, shifted[7:0]};
      LHU:     load_data_o = {16'b0, shifted[15:0]};
      default: load_data_o = shifted;
    endcase
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
// One fetch in flight; read data must arrive exactly one cycle after the grant
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv32_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     reset_i,
  output bus_req_t bus_o,
  input  logic     grant_i,
  input  word_t    rdata_i,
  input  logic     retire_i,
  input  word_t    next_pc_i,
  output instr_t   instr_o,
  output logic     instr_valid_o,
  output word_t    pc_o
);

  typedef enum logic [1:0] {REQUEST, WAIT, EXECUTE} fetch_state_t;

  fetch_state_t state;
  word_t        pc_q;
  instr_t       instr_q;
  logic         req_q;
  logic         valid_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= REQUEST;
      pc_q    <= RESET_PC;
      req_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        REQUEST: begin
          // Hold the strobe until the arbiter takes it
          if (req_q && grant_i) begin
            req_q <= 1'b0;
            state <= WAIT;
          end else begin
            req_q <= 1'b1;
          end
        end
        WAIT: begin
          valid_q <= 1'b1;
          state   <= EXECUTE;
        end
        default: begin
          // Stays here for good after halt or illegal
          if (retire_i) begin
            pc_q  <= next_pc_i;
            req_q <= 1'b1;
            state <= REQUEST;
          end
        end
      endcase
    end
  end

  // Instruction word arrives in WAIT
  always_ff @(posedge clk) begin
    if (state == WAIT) begin
      instr_q <= rdata_i;
    end
  end

  assign bus_o.req   = req_q;
  assign bus_o.we    = 1'b0;
  assign bus_o.be    = 4'hf;
  assign bus_o.addr  = pc_q;
  assign bus_o.wdata = '0;

  assign instr_o       = instr_q;
  assign instr_valid_o = valid_q;
  assign pc_o          = pc_q;

endmodule

`default_nettype wire

// File: source/reg_file.sv
// Two async read ports, one sync write port; x0 reads zero as writes to it are dropped
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv32_pkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  input  reg_idx_t rd_i,
  input  logic     wen_i,
  input  word_t    wdata_i,
  output word_t    rdata1_o,
  output word_t    rdata2_o
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

`default_nettype wire

// File: source/control_unit.sv
// RV32I base decode only; SYSTEM, MISC-MEM and any unknown opcode flag illegal
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv32_pkg::*; (
  input  instr_t instr_i,
  output ctrl_t  ctrl_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    ctrl_o             = '0;
    ctrl_o.rs1         = instr_i[19:15];
    ctrl_o.rs2         = instr_i[24:20];
    ctrl_o.rd          = instr_i[11:7];
    ctrl_o.load_type   = load_t'(funct3);
    ctrl_o.branch_type = branch_t'(funct3);
    ctrl_o.asel        = (opcode == AUIPC) ? ASEL_PC : ASEL_RS1;
    ctrl_o.bsel        = (opcode == REGREG || opcode == BRANCH) ? BSEL_RS2 : BSEL_IMM;
    ctrl_o.dren        = (opcode == LOAD);
    ctrl_o.dwen        = (opcode == STORE);
    ctrl_o.branch      = (opcode == BRANCH);
    ctrl_o.jump        = (opcode == JAL || opcode == JALR);
    ctrl_o.jalr        = (opcode == JALR);
    // Jump-to-self ends the program
    ctrl_o.halt        = (instr_i == 32'h0000006f);
    ctrl_o.alu_op      = ALU_ADD;

    case (opcode)
      IMMED, LOAD, JALR: ctrl_o.imm = imm_i;
      STORE:             ctrl_o.imm = imm_s;
      BRANCH:            ctrl_o.imm = imm_b;
      LUI, AUIPC:        ctrl_o.imm = imm_u;
      JAL:               ctrl_o.imm = imm_j;
      default:           ctrl_o.imm = '0;
    endcase

    case (opcode)
      LOAD:      ctrl_o.wsel = WSEL_LOAD;
      JAL, JALR: ctrl_o.wsel = WSEL_PC4;
      LUI:       ctrl_o.wsel = WSEL_UIMM;
      default:   ctrl_o.wsel = WSEL_ALU;
    endcase

    case (opcode)
      LUI, AUIPC, JAL, JALR, LOAD, IMMED, REGREG: ctrl_o.wen = 1'b1;
      default:                                    ctrl_o.wen = 1'b0;
    endcase

    // funct3 picks the operation, bit 30 splits SUB and SRA
    if (opcode == IMMED || opcode == REGREG) begin
      case (funct3)
        3'b000:  ctrl_o.alu_op = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
        3'b001:  ctrl_o.alu_op = ALU_SLL;
        3'b010:  ctrl_o.alu_op = ALU_SLT;
        3'b011:  ctrl_o.alu_op = ALU_SLTU;
        3'b100:  ctrl_o.alu_op = ALU_XOR;
        3'b101:  ctrl_o.alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
        3'b110:  ctrl_o.alu_op = ALU_OR;
        default: ctrl_o.alu_op = ALU_AND;
      endcase
    end

    case (opcode)
      REGREG:                                            ctrl_o.illegal = instr_i[25];
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, IMMED: ctrl_o.illegal = 1'b0;
      default:                                           ctrl_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv32_pkg.sv
// Shared RV32I types; no CSR, SYSTEM or MISC-MEM encodings are defined
`default_nettype none

package rv32_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // Encoded as funct3, so stores reuse the LB/LH/LW values for size
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [1:0] {WSEL_LOAD, WSEL_PC4, WSEL_UIMM, WSEL_ALU} wsel_t;
  typedef enum logic {ASEL_RS1, ASEL_PC} asel_t;
  typedef enum logic {BSEL_RS2, BSEL_IMM} bsel_t;

  // Complete decode of one instruction
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    asel_t    asel;
    bsel_t    bsel;
    alu_op_t  alu_op;
    wsel_t    wsel;
    logic     wen;
    logic     dren;
    logic     dwen;
    load_t    load_type;
    branch_t  branch_type;
    logic     branch;
    logic     jump;
    logic     jalr;
    logic     halt;
    logic     illegal;
  } ctrl_t;

  typedef struct packed {
    logic       req;
    logic       we;
    logic [3:0] be;
    word_t      addr;
    word_t      wdata;
  } bus_req_t;

endpackage

`default_nettype wire
